//--- glb_load.f
rtl/glb_param_pkg.sv
rtl/glb_dma_pkg.sv
rtl/glb_bank_sram.sv
rtl/glb_ld_header_queue.sv
rtl/glb_ld_addr_gen.sv
rtl/glb_ld_unpacker.sv
rtl/glb_load_tile.sv
test/tb_glb_load_tile.sv

//--- run_sim.sh
#!/bin/sh
# build and run the load tile testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_glb_load_tile \
    -f glb_load.f \
    -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST OK"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- test/tb_glb_load_tile.sv
// ======================================================================
// load tile testbench
// fills the bank, programs descriptors and checks the fabric stream,
// done pulses and invalidate pulses against a reference memory model
// ======================================================================
`timescale 1ns/10ps

module tb_glb_load_tile;
    import glb_param_pkg::*;
    import glb_dma_pkg::*;

    localparam int QUEUE_DEPTH     = 4;
    localparam int BANK_ADDR_WIDTH = 12;
    localparam int NUM_BEATS       = 2**(BANK_ADDR_WIDTH - 3);
    // words and descriptors of all tests, zero length one left out
    localparam int TOTAL_WORDS     = 16 + 11 + 5 + 7 + 4 + 9 + 40 + 13 + 30;
    localparam int TOTAL_DESC      = 9;
    localparam int WORST_CYCLES    = (TOTAL_WORDS + 8 * TOTAL_DESC) * 8;
    localparam int WATCHDOG_NS     = (WORST_CYCLES + NUM_BEATS + 600) * 100;

    logic clk;
    logic reset;
    logic clk_en;
    logic host_wr_en;
    logic [8:0] host_wr_addr;
    logic [BANK_DATA_WIDTH-1:0] host_wr_data;
    logic cfg_load_dma_on;
    logic cfg_load_dma_auto_on;
    logic [QUEUE_DEPTH-1:0] cfg_hdr_valid;
    logic [QUEUE_DEPTH-1:0][BANK_ADDR_WIDTH-1:0] cfg_hdr_start_addr;
    logic [QUEUE_DEPTH-1:0][MAX_NUM_WORDS_WIDTH-1:0] cfg_hdr_num_words;
    logic [QUEUE_DEPTH-1:0] cfg_load_dma_invalidate_pulse;
    logic [CGRA_DATA_WIDTH-1:0] stream_data_g2f;
    logic stream_data_valid_g2f;
    logic stream_g2f_done_pulse;

    // reference bank contents and expected stream
    logic [BANK_DATA_WIDTH-1:0] ref_mem [NUM_BEATS];
    logic [CGRA_DATA_WIDTH-1:0] exp_mem [1024];
    int done_mark [16];
    int wr_idx;
    int n_desc;
    int done_expect;
    int prog_cnt [QUEUE_DEPTH];
    logic flush;

    // monitor side
    int rd_idx;
    int done_idx;
    int done_seen;
    int words_seen;
    int inval_cnt [QUEUE_DEPTH];
    logic [CGRA_DATA_WIDTH-1:0] exp_head;
    int done_target;
    logic [QUEUE_DEPTH-1:0] inval_ok;
    int errors;

    glb_load_tile #(
        .QUEUE_DEPTH     (QUEUE_DEPTH),
        .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH)
    ) dut0 (
        .clk                           (clk),
        .reset                         (reset),
        .clk_en                        (clk_en),
        .host_wr_en                    (host_wr_en),
        .host_wr_addr                  (host_wr_addr),
        .host_wr_data                  (host_wr_data),
        .cfg_load_dma_on               (cfg_load_dma_on),
        .cfg_load_dma_auto_on          (cfg_load_dma_auto_on),
        .cfg_hdr_valid                 (cfg_hdr_valid),
        .cfg_hdr_start_addr            (cfg_hdr_start_addr),
        .cfg_hdr_num_words             (cfg_hdr_num_words),
        .cfg_load_dma_invalidate_pulse (cfg_load_dma_invalidate_pulse),
        .stream_data_g2f               (stream_data_g2f),
        .stream_data_valid_g2f         (stream_data_valid_g2f),
        .stream_g2f_done_pulse         (stream_g2f_done_pulse)
    );

    always #50 clk = ~clk;

    task automatic flag_error(input string msg);
        errors++;
        $display("FAIL %0t: %s", $time, msg);
    endtask

    // pops one expected word per valid, follows done pulses
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_idx     <= 0;
            done_idx   <= 0;
            done_seen  <= 0;
            words_seen <= 0;
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                inval_cnt[i] <= 0;
            end
        end else begin
            // aborted descriptor drops its remaining words
            if (flush) begin
                rd_idx   <= wr_idx;
                done_idx <= n_desc;
            end else begin
                if (stream_data_valid_g2f) begin
                    rd_idx <= rd_idx + 1;
                end
                if (stream_g2f_done_pulse) begin
                    done_idx <= done_idx + 1;
                end
            end
            if (stream_data_valid_g2f) begin
                words_seen <= words_seen + 1;
            end
            if (stream_g2f_done_pulse) begin
                done_seen <= done_seen + 1;
            end
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                if (cfg_load_dma_invalidate_pulse[i]) begin
                    inval_cnt[i] <= inval_cnt[i] + 1;
                end
            end
        end
    end

    assign exp_head    = exp_mem[rd_idx[9:0]];
    assign done_target = done_mark[done_idx[3:0]];

    // an entry may pulse only for a descriptor it was given
    always_comb begin
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            inval_ok[i] = inval_cnt[i] < prog_cnt[i];
        end
    end

    a_word: assert property (@(posedge clk) disable iff (reset)
        stream_data_valid_g2f |-> (rd_idx < wr_idx) && (stream_data_g2f == exp_head))
        else flag_error($sformatf("stream word %0h, expected %0h",
                        $sampled(stream_data_g2f), $sampled(exp_head)));

    a_done: assert property (@(posedge clk) disable iff (reset)
        stream_g2f_done_pulse |-> (done_idx < n_desc) && (rd_idx == done_target))
        else flag_error("done pulse with expected words left or no descriptor");

    a_inval: assert property (@(posedge clk) disable iff (reset)
        (cfg_load_dma_invalidate_pulse & ~inval_ok) == '0)
        else flag_error("invalidate pulse on an entry without a taken descriptor");

    a_frozen: assert property (@(posedge clk) disable iff (reset)
        !clk_en |-> !stream_data_valid_g2f && !stream_g2f_done_pulse &&
                    (cfg_load_dma_invalidate_pulse == '0))
        else flag_error("valid or pulse while clk_en is low");

    a_off: assert property (@(posedge clk) disable iff (reset)
        !cfg_load_dma_on |-> !stream_data_valid_g2f)
        else flag_error("stream valid while the load dma is off");

    // descriptor setup plus the words it should stream
    task automatic set_descriptor(input int entry, input int addr, input int words);
        int w;
        cfg_hdr_start_addr[entry] = addr[BANK_ADDR_WIDTH-1:0];
        cfg_hdr_num_words[entry]  = words[MAX_NUM_WORDS_WIDTH-1:0];
        cfg_hdr_valid[entry]      = 1'b1;
        if (words != 0) begin
            for (int k = 0; k < words; k++) begin
                w = addr / 2 + k;
                exp_mem[wr_idx[9:0]] = ref_mem[w[10:2]][w[1:0]*CGRA_DATA_WIDTH +: 16];
                wr_idx++;
            end
            done_mark[n_desc[3:0]] = wr_idx;
            n_desc++;
            done_expect++;
            prog_cnt[entry]++;
        end
    endtask

    // valid low for one cycle so the next setup is a rising edge
    task automatic clear_valids();
        cfg_hdr_valid = '0;
        @(posedge clk);
        #1;
    endtask

    task automatic wait_done();
        while (done_seen < done_expect) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish in %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int abort_at;
        void'($urandom(30959));
        clk                  = 1'b0;
        reset                = 1'b1;
        clk_en               = 1'b1;
        host_wr_en           = 1'b0;
        host_wr_addr         = '0;
        host_wr_data         = '0;
        cfg_load_dma_on      = 1'b0;
        cfg_load_dma_auto_on = 1'b0;
        cfg_hdr_valid        = '0;
        cfg_hdr_start_addr   = '0;
        cfg_hdr_num_words    = '0;
        flush                = 1'b0;
        wr_idx               = 0;
        n_desc               = 0;
        done_expect          = 0;
        errors               = 0;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            prog_cnt[i] = 0;
        end
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        // everything quiet coming out of reset
        assert (!stream_data_valid_g2f && !stream_g2f_done_pulse &&
                cfg_load_dma_invalidate_pulse == '0 && !dut0.rd_req_valid && !dut0.rd_en)
            else flag_error("outputs not low after reset");

        // random bank fill through the host port
        for (int b = 0; b < NUM_BEATS; b++) begin
            host_wr_en   = 1'b1;
            host_wr_addr = b[8:0];
            host_wr_data = {$urandom(), $urandom()};
            ref_mem[b]   = host_wr_data;
            @(posedge clk);
            #1;
        end
        host_wr_en      = 1'b0;
        cfg_load_dma_on = 1'b1;

        // aligned, then unaligned with an odd length, manual mode
        set_descriptor(0, 'h000, 16);
        wait_done();
        clear_valids();
        set_descriptor(0, 'h10e, 11);
        wait_done();

        // auto mode walks all four entries
        clear_valids();
        cfg_load_dma_auto_on = 1'b1;
        set_descriptor(0, 'h200, 5);
        set_descriptor(1, 'h232, 7);
        set_descriptor(2, 'h400, 4);
        set_descriptor(3, 'h5f6, 9);
        wait_done();
        cfg_load_dma_auto_on = 1'b0;

        // zero length descriptor is never taken
        clear_valids();
        set_descriptor(0, 'h040, 0);
        repeat (20) @(posedge clk);
        #1;

        // setup while off, then abort part way through
        cfg_load_dma_on = 1'b0;
        clear_valids();
        set_descriptor(0, 'h300, 40);
        repeat (20) @(posedge clk);
        #1;
        cfg_load_dma_on = 1'b1;
        abort_at = wr_idx - 30;
        while (rd_idx < abort_at) begin
            @(posedge clk);
            #1;
        end
        cfg_load_dma_on = 1'b0;
        flush           = 1'b1;
        done_expect--;
        @(posedge clk);
        #1;
        flush = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        cfg_load_dma_on = 1'b1;
        clear_valids();
        set_descriptor(0, 'h080, 13);
        wait_done();

        // random freeze periods during a transfer
        clear_valids();
        set_descriptor(0, 'h700, 30);
        while (done_seen < done_expect) begin
            @(posedge clk);
            #1;
            clk_en = ($urandom() % 4) != 0;
        end
        clk_en = 1'b1;
        repeat (10) @(posedge clk);
        #1;

        assert (rd_idx == wr_idx)
            else flag_error($sformatf("%0d expected words never arrived", wr_idx - rd_idx));
        assert (done_seen == done_expect)
            else flag_error($sformatf("%0d done pulses, expected %0d", done_seen, done_expect));
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            assert (inval_cnt[i] == prog_cnt[i])
                else flag_error($sformatf("entry %0d had %0d invalidate pulses, expected %0d",
                                i, inval_cnt[i], prog_cnt[i]));
        end

        $display("errors %0d, stream words %0d, done pulses %0d", errors, words_seen, done_seen);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- rtl/glb_load_tile.sv
// ======================================================================
// global buffer load tile
// header queue, address generator, bank sram and unpacker of the
// load path from the bank to the fabric stream
// ======================================================================
`timescale 1ns/10ps

module glb_load_tile #(
    parameter int QUEUE_DEPTH     = 4,
    parameter int BANK_ADDR_WIDTH = 12,
    localparam int BEAT_ADDR_WIDTH =
        BANK_ADDR_WIDTH - $clog2(glb_param_pkg::BANK_DATA_WIDTH / 8)
) (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        clk_en,
    // host write port
    input  logic                                        host_wr_en,
    input  logic [BEAT_ADDR_WIDTH-1:0]                  host_wr_addr,
    input  logic [glb_param_pkg::BANK_DATA_WIDTH-1:0]   host_wr_data,
    // configuration
    input  logic                                        cfg_load_dma_on,
    input  logic                                        cfg_load_dma_auto_on,
    input  logic [QUEUE_DEPTH-1:0]                      cfg_hdr_valid,
    input  logic [QUEUE_DEPTH-1:0][BANK_ADDR_WIDTH-1:0] cfg_hdr_start_addr,
    input  logic [QUEUE_DEPTH-1:0][glb_dma_pkg::MAX_NUM_WORDS_WIDTH-1:0] cfg_hdr_num_words,
    output logic [QUEUE_DEPTH-1:0]                      cfg_load_dma_invalidate_pulse,
    // fabric stream
    output logic [glb_param_pkg::CGRA_DATA_WIDTH-1:0]   stream_data_g2f,
    output logic                                        stream_data_valid_g2f,
    output logic                                        stream_g2f_done_pulse
);
    import glb_param_pkg::*;
    import glb_dma_pkg::*;

    // selected header
    logic                           hdr_valid;
    logic [BANK_ADDR_WIDTH-1:0]     hdr_start_addr;
    logic [MAX_NUM_WORDS_WIDTH-1:0] hdr_num_words;
    logic                           hdr_take;

    // read request between address generator and unpacker
    logic                           rd_req_valid;
    logic                           rd_req_ready;
    logic [BEAT_ADDR_WIDTH-1:0]     rd_beat_addr;
    logic [LANE_SEL_WIDTH-1:0]      rd_first_lane;
    logic [LANE_SEL_WIDTH-1:0]      rd_last_lane;
    logic                           rd_is_final;
    logic                           beat_done;

    logic                           rd_en;
    logic [BANK_DATA_WIDTH-1:0]     rd_data;

    // sram read on each accepted request
    assign rd_en = rd_req_valid && rd_req_ready;

    glb_ld_header_queue #(
        .QUEUE_DEPTH     (QUEUE_DEPTH),
        .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH)
    ) header_queue0 (
        .clk                           (clk),
        .reset                         (reset),
        .clk_en                        (clk_en),
        .cfg_load_dma_auto_on          (cfg_load_dma_auto_on),
        .cfg_hdr_valid                 (cfg_hdr_valid),
        .cfg_hdr_start_addr            (cfg_hdr_start_addr),
        .cfg_hdr_num_words             (cfg_hdr_num_words),
        .hdr_take                      (hdr_take),
        .hdr_valid                     (hdr_valid),
        .hdr_start_addr                (hdr_start_addr),
        .hdr_num_words                 (hdr_num_words),
        .cfg_load_dma_invalidate_pulse (cfg_load_dma_invalidate_pulse)
    );

    glb_ld_addr_gen #(
        .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH)
    ) addr_gen0 (
        .clk             (clk),
        .reset           (reset),
        .clk_en          (clk_en),
        .cfg_load_dma_on (cfg_load_dma_on),
        .hdr_valid       (hdr_valid),
        .hdr_start_addr  (hdr_start_addr),
        .hdr_num_words   (hdr_num_words),
        .hdr_take        (hdr_take),
        .rd_req_valid    (rd_req_valid),
        .rd_req_ready    (rd_req_ready),
        .rd_beat_addr    (rd_beat_addr),
        .rd_first_lane   (rd_first_lane),
        .rd_last_lane    (rd_last_lane),
        .rd_is_final     (rd_is_final),
        .beat_done       (beat_done)
    );

    glb_bank_sram #(
        .BANK_ADDR_WIDTH (BANK_ADDR_WIDTH)
    ) bank_sram0 (
        .clk          (clk),
        .clk_en       (clk_en),
        .host_wr_en   (host_wr_en),
        .host_wr_addr (host_wr_addr),
        .host_wr_data (host_wr_data),
        .rd_en        (rd_en),
        .rd_addr      (rd_beat_addr),
        .rd_data      (rd_data)
    );

    glb_ld_unpacker unpacker0 (
        .clk                   (clk),
        .reset                 (reset),
        .clk_en                (clk_en),
        .cfg_load_dma_on       (cfg_load_dma_on),
        .rd_req_valid          (rd_req_valid),
        .rd_req_ready          (rd_req_ready),
        .rd_first_lane         (rd_first_lane),
        .rd_last_lane          (rd_last_lane),
        .rd_is_final           (rd_is_final),
        .rd_data               (rd_data),
        .beat_done             (beat_done),
        .stream_data_g2f       (stream_data_g2f),
        .stream_data_valid_g2f (stream_data_valid_g2f),
        .stream_g2f_done_pulse (stream_g2f_done_pulse)
    );

endmodule

//--- rtl/glb_ld_unpacker.sv
// ======================================================================
// load dma unpacker
// holds one returned bank word and streams its lanes to the fabric,
// then flags the end of the descriptor with a done pulse
// ======================================================================
`timescale 1ns/10ps

module glb_ld_unpacker (
    input  logic                                      clk,
    input  logic                                      reset,
    input  logic                                      clk_en,
    input  logic                                      cfg_load_dma_on,
    input  logic                                      rd_req_valid,
    output logic                                      rd_req_ready,
    input  logic [glb_param_pkg::LANE_SEL_WIDTH-1:0]  rd_first_lane,
    input  logic [glb_param_pkg::LANE_SEL_WIDTH-1:0]  rd_last_lane,
    input  logic                                      rd_is_final,
    input  logic [glb_param_pkg::BANK_DATA_WIDTH-1:0] rd_data,
    output logic                                      beat_done,
    output logic [glb_param_pkg::CGRA_DATA_WIDTH-1:0] stream_data_g2f,
    output logic                                      stream_data_valid_g2f,
    output logic                                      stream_g2f_done_pulse
);
    import glb_param_pkg::*;
    import glb_dma_pkg::*;

    ul_state_e                 state;
    logic [LANE_SEL_WIDTH-1:0] lane_cur;
    logic [LANE_SEL_WIDTH-1:0] last_lane;
    logic                      final_beat;
    logic [BANK_DATA_WIDTH-1:0] beat_data;
    logic                      last_word;
    logic                      done_r;

    // one bank word in flight or buffered at a time
    assign rd_req_ready = (state == EMPTY);

    assign last_word = (state == STREAM) && (lane_cur == last_lane);
    assign beat_done = last_word && final_beat && clk_en && cfg_load_dma_on;

    assign stream_data_g2f       = beat_data[lane_cur*CGRA_DATA_WIDTH +: CGRA_DATA_WIDTH];
    assign stream_data_valid_g2f = (state == STREAM) && clk_en && cfg_load_dma_on;
    assign stream_g2f_done_pulse = done_r && clk_en;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state      <= EMPTY;
            lane_cur   <= '0;
            last_lane  <= '0;
            final_beat <= 1'b0;
            done_r     <= 1'b0;
        end else if (clk_en) begin
            // done pulse trails the last word by one cycle
            done_r <= beat_done;
            if (!cfg_load_dma_on) begin
                state <= EMPTY;
            end else begin
                case (state)
                    // lane span and final flag taken on the handshake
                    EMPTY: begin
                        if (rd_req_valid) begin
                            lane_cur   <= rd_first_lane;
                            last_lane  <= rd_last_lane;
                            final_beat <= rd_is_final;
                            state      <= WAIT_DATA;
                        end
                    end
                    // sram read latency
                    WAIT_DATA: state <= STREAM;
                    STREAM: begin
                        if (lane_cur == last_lane) begin
                            state <= EMPTY;
                        end else begin
                            lane_cur <= lane_cur + 1'b1;
                        end
                    end
                    default: state <= EMPTY;
                endcase
            end
        end
    end

    // bank word from the sram
    always_ff @(posedge clk) begin
        if (clk_en && state == WAIT_DATA) begin
            beat_data <= rd_data;
        end
    end

    a_done_single: assert property (@(posedge clk) disable iff (reset)
        stream_g2f_done_pulse |=> !stream_g2f_done_pulse);

    // lanes go out in order inside the span from the address generator
    a_valid_state: assert property (@(posedge clk) disable iff (reset)
        stream_data_valid_g2f |-> (state == STREAM) && (lane_cur <= last_lane));

endmodule

//--- rtl/glb_ld_addr_gen.sv
// ======================================================================
// load dma address generator
// walks one descriptor and issues bank reads, each with its lane span
// ======================================================================
`timescale 1ns/10ps

module glb_ld_addr_gen #(
    parameter int BANK_ADDR_WIDTH = 12,
    localparam int BEAT_ADDR_WIDTH =
        BANK_ADDR_WIDTH - $clog2(glb_param_pkg::BANK_DATA_WIDTH / 8)
) (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        clk_en,
    input  logic                                        cfg_load_dma_on,
    input  logic                                        hdr_valid,
    input  logic [BANK_ADDR_WIDTH-1:0]                  hdr_start_addr,
    input  logic [glb_dma_pkg::MAX_NUM_WORDS_WIDTH-1:0] hdr_num_words,
    output logic                                        hdr_take,
    output logic                                        rd_req_valid,
    input  logic                                        rd_req_ready,
    output logic [BEAT_ADDR_WIDTH-1:0]                  rd_beat_addr,
    output logic [glb_param_pkg::LANE_SEL_WIDTH-1:0]    rd_first_lane,
    output logic [glb_param_pkg::LANE_SEL_WIDTH-1:0]    rd_last_lane,
    output logic                                        rd_is_final,
    input  logic                                        beat_done
);
    import glb_param_pkg::*;
    import glb_dma_pkg::*;

    localparam int BYTE_OFFSET = $clog2(BANK_DATA_WIDTH / 8);
    localparam int LANE_LSB    = $clog2(CGRA_DATA_WIDTH / 8);

    ld_state_e                      state;
    ld_state_e                      next_state;
    logic [MAX_NUM_WORDS_WIDTH-1:0] rem_cnt;
    logic [BEAT_ADDR_WIDTH-1:0]     beat_addr;
    logic [LANE_SEL_WIDTH-1:0]      first_lane;
    logic [MAX_NUM_WORDS_WIDTH-1:0] lanes_left;
    logic [MAX_NUM_WORDS_WIDTH-1:0] span_len;
    logic                           hdr_usable;
    logic                           req_fire;

    // zero length descriptors are never taken
    assign hdr_usable = hdr_valid && (hdr_num_words != '0);
    assign hdr_take   = (state == IDLE) && hdr_usable && clk_en && cfg_load_dma_on;

    assign rd_req_valid = (state == ISSUE);
    assign req_fire     = rd_req_valid && rd_req_ready && clk_en;

    // lanes from the start lane up to the end of the beat
    assign lanes_left  = MAX_NUM_WORDS_WIDTH'(LANES_PER_BEAT) - MAX_NUM_WORDS_WIDTH'(first_lane);
    assign rd_is_final = (rem_cnt <= lanes_left);
    assign span_len    = rd_is_final ? rem_cnt : lanes_left;

    assign rd_beat_addr  = beat_addr;
    assign rd_first_lane = first_lane;
    // final beat stops at the lane of the last word
    assign rd_last_lane  = rd_is_final ? first_lane + LANE_SEL_WIDTH'(rem_cnt - 1'b1)
                                       : LANE_SEL_WIDTH'(LANES_PER_BEAT - 1);

    always_comb begin
        next_state = state;
        case (state)
            OFF:   next_state = IDLE;
            IDLE: begin
                if (hdr_usable) begin
                    next_state = ISSUE;
                end
            end
            ISSUE: begin
                if (rd_req_ready && rd_is_final) begin
                    next_state = DRAIN;
                end
            end
            // hold until the unpacker has sent the last word
            DRAIN: begin
                if (beat_done) begin
                    next_state = DONE;
                end
            end
            DONE:    next_state = IDLE;
            default: next_state = OFF;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= OFF;
        end else if (clk_en) begin
            state <= cfg_load_dma_on ? next_state : OFF;
        end
    end

    // word count, beat address and start lane
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rem_cnt    <= '0;
            beat_addr  <= '0;
            first_lane <= '0;
        end else if (clk_en) begin
            if (hdr_take) begin
                rem_cnt    <= hdr_num_words;
                beat_addr  <= hdr_start_addr[BANK_ADDR_WIDTH-1:BYTE_OFFSET];
                first_lane <= hdr_start_addr[LANE_LSB +: LANE_SEL_WIDTH];
            end else if (req_fire) begin
                rem_cnt    <= rem_cnt - span_len;
                beat_addr  <= beat_addr + 1'b1;
                first_lane <= '0;
            end
        end
    end

    // request held steady until the unpacker accepts it
    a_req_stable: assert property (@(posedge clk) disable iff (reset)
        (rd_req_valid && !rd_req_ready) |=>
            $stable({rd_beat_addr, rd_first_lane, rd_last_lane, rd_is_final}));

    // every accepted beat shrinks the count without wrapping
    a_no_wrap: assert property (@(posedge clk) disable iff (reset)
        req_fire |=> rem_cnt < $past(rem_cnt));

endmodule

//--- rtl/glb_ld_header_queue.sv
// ======================================================================
// load dma header queue
// captures descriptors on a rising valid bit, presents the selected
// entry to the address generator and pulses invalidate on take
// ======================================================================
`timescale 1ns/10ps

module glb_ld_header_queue #(
    parameter int QUEUE_DEPTH     = 4,
    parameter int BANK_ADDR_WIDTH = 12
) (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    clk_en,
    input  logic                                    cfg_load_dma_auto_on,
    input  logic [QUEUE_DEPTH-1:0]                  cfg_hdr_valid,
    input  logic [QUEUE_DEPTH-1:0][BANK_ADDR_WIDTH-1:0] cfg_hdr_start_addr,
    input  logic [QUEUE_DEPTH-1:0][glb_dma_pkg::MAX_NUM_WORDS_WIDTH-1:0] cfg_hdr_num_words,
    input  logic                                    hdr_take,
    output logic                                    hdr_valid,
    output logic [BANK_ADDR_WIDTH-1:0]              hdr_start_addr,
    output logic [glb_dma_pkg::MAX_NUM_WORDS_WIDTH-1:0] hdr_num_words,
    output logic [QUEUE_DEPTH-1:0]                  cfg_load_dma_invalidate_pulse
);
    import glb_dma_pkg::*;

    localparam int SEL_WIDTH = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;

    logic [QUEUE_DEPTH-1:0]                          valid_d1;
    logic [QUEUE_DEPTH-1:0]                          valid_rise;
    logic [QUEUE_DEPTH-1:0]                          ent_valid;
    logic [QUEUE_DEPTH-1:0][BANK_ADDR_WIDTH-1:0]     ent_start_addr;
    logic [QUEUE_DEPTH-1:0][MAX_NUM_WORDS_WIDTH-1:0] ent_num_words;
    logic [QUEUE_DEPTH-1:0]                          inval_r;
    logic [SEL_WIDTH-1:0]                            sel_ptr;
    logic [SEL_WIDTH-1:0]                            sel;

    assign valid_rise = cfg_hdr_valid & ~valid_d1;

    // manual mode always serves entry 0
    assign sel = cfg_load_dma_auto_on ? sel_ptr : '0;

    // valid edge detect and internal entry valid
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid_d1  <= '0;
            ent_valid <= '0;
        end else if (clk_en) begin
            valid_d1 <= cfg_hdr_valid;
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                // a fresh descriptor wins over a take of the old one
                if (valid_rise[i]) begin
                    ent_valid[i] <= 1'b1;
                end else if (hdr_take && sel == SEL_WIDTH'(i)) begin
                    ent_valid[i] <= 1'b0;
                end
            end
        end
    end

    // descriptor fields
    always_ff @(posedge clk) begin
        if (clk_en) begin
            for (int i = 0; i < QUEUE_DEPTH; i++) begin
                if (valid_rise[i]) begin
                    ent_start_addr[i] <= cfg_hdr_start_addr[i];
                    ent_num_words[i]  <= cfg_hdr_num_words[i];
                end
            end
        end
    end

    // invalidate pulse one cycle after take, select pointer wraps
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            inval_r <= '0;
            sel_ptr <= '0;
        end else if (clk_en) begin
            inval_r <= '0;
            if (hdr_take) begin
                inval_r[sel] <= 1'b1;
            end
            if (!cfg_load_dma_auto_on) begin
                sel_ptr <= '0;
            end else if (hdr_take) begin
                sel_ptr <= (sel_ptr == SEL_WIDTH'(QUEUE_DEPTH - 1)) ? '0 : sel_ptr + 1'b1;
            end
        end
    end

    assign hdr_valid      = ent_valid[sel];
    assign hdr_start_addr = ent_start_addr[sel];
    assign hdr_num_words  = ent_num_words[sel];

    // no pulse shows while the tile is frozen
    assign cfg_load_dma_invalidate_pulse = inval_r & {QUEUE_DEPTH{clk_en}};

    // address generator only takes a header this queue offers
    a_take_valid: assert property (@(posedge clk) disable iff (reset)
        hdr_take |-> hdr_valid);

endmodule

//--- rtl/glb_bank_sram.sv
// ======================================================================
// global buffer bank sram
// host write port plus a registered read port for the load dma
// ======================================================================
`timescale 1ns/10ps

module glb_bank_sram #(
    parameter int BANK_ADDR_WIDTH = 12,
    localparam int BEAT_ADDR_WIDTH =
        BANK_ADDR_WIDTH - $clog2(glb_param_pkg::BANK_DATA_WIDTH / 8)
) (
    input  logic                                     clk,
    input  logic                                     clk_en,
    input  logic                                     host_wr_en,
    input  logic [BEAT_ADDR_WIDTH-1:0]               host_wr_addr,
    input  logic [glb_param_pkg::BANK_DATA_WIDTH-1:0] host_wr_data,
    input  logic                                     rd_en,
    input  logic [BEAT_ADDR_WIDTH-1:0]               rd_addr,
    output logic [glb_param_pkg::BANK_DATA_WIDTH-1:0] rd_data
);
    import glb_param_pkg::*;

    logic [BANK_DATA_WIDTH-1:0] mem [2**BEAT_ADDR_WIDTH];

    // host side keeps running while the tile is frozen
    always_ff @(posedge clk) begin
        if (host_wr_en) begin
            mem[host_wr_addr] <= host_wr_data;
        end
    end

    // read data lands one enabled cycle after the request
    always_ff @(posedge clk) begin
        if (clk_en && rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

//--- rtl/glb_dma_pkg.sv
// ======================================================================
// load dma descriptor and control definitions
// word count width and the FSM state encodings of the load path
// ======================================================================
package glb_dma_pkg;

    // descriptor word count, in stream words
    parameter int MAX_NUM_WORDS_WIDTH = 12;

    // address generator states
    typedef enum logic [2:0] {
        OFF,
        IDLE,
        ISSUE,
        DRAIN,
        DONE
    } ld_state_e;

    // unpacker states
    typedef enum logic [1:0] {
        EMPTY,
        WAIT_DATA,
        STREAM
    } ul_state_e;

endpackage

//--- rtl/glb_param_pkg.sv
// ======================================================================
// global buffer data widths
// bank word and fabric stream word sizes shared by the load path
// ======================================================================
package glb_param_pkg;

    // one fabric stream word
    parameter int CGRA_DATA_WIDTH = 16;

    // one bank sram word
    parameter int BANK_DATA_WIDTH = 64;

    // stream words packed in one bank word
    parameter int LANES_PER_BEAT = BANK_DATA_WIDTH / CGRA_DATA_WIDTH;

    // lane select inside a bank word
    parameter int LANE_SEL_WIDTH = $clog2(LANES_PER_BEAT);

endpackage
